//--- hdl/dual_issue_pkg.sv
package dual_issue_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_ADDIU,
        ALU_ORI,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_type_t;

    // same word, two field layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic                  uses_rs;
        logic                  uses_rt;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] waddr;
        alu_op_e               alu_op;
        logic                  src_b_imm;
        // shift amount rides in imm_value when set
        logic                  src_a_shamt;
        logic [DATA_W-1:0]     imm_value;
    } lane_ctrl_t;

    typedef struct packed {
        logic              valid;
        lane_ctrl_t        ctrl;
        logic [DATA_W-1:0] rs_value;
        logic [DATA_W-1:0] rt_value;
    } exec_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]     wdata;
    } retire_t;

endpackage

//--- hdl/inst_fifo.sv
module inst_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            push_i,
    input  dual_issue_pkg::inst_u           push_data_i,
    input  logic                            pop_one_i,
    input  logic                            pop_two_i,
    output dual_issue_pkg::inst_u           head_o,
    output dual_issue_pkg::inst_u           next_o,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o,
    output logic                            full_o
);
    import dual_issue_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    inst_u            mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_next_ptr;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic [1:0]       pop_num;

    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
    assign do_push = push_i && !full_o;
    // pop_two wins, the top never raises both
    assign pop_num = pop_two_i ? 2'd2 : {1'b0, pop_one_i};

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(do_push);
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_num);
            count_q  <= count_q + CNT_W'(do_push) - CNT_W'(pop_num);
        end
    end

    // pointers wrap on their own since depth is a power of two
    assign rd_next_ptr = rd_ptr_q + PTR_W'(1);
    assign head_o      = mem_q[rd_ptr_q];
    assign next_o      = mem_q[rd_next_ptr];
    assign count_o     = count_q;

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
    input  dual_issue_pkg::inst_u      inst_i,
    output dual_issue_pkg::lane_ctrl_t ctrl_o
);
    import dual_issue_pkg::*;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.rs     = inst_i.r.rs;
        ctrl_o.rt     = inst_i.r.rt;
        ctrl_o.alu_op = ALU_ADDU;
        case (inst_i.r.op)
            OP_SPECIAL: begin
                ctrl_o.waddr   = inst_i.r.rd;
                ctrl_o.uses_rs = 1'b1;
                ctrl_o.uses_rt = 1'b1;
                ctrl_o.reg_wen = 1'b1;
                case (inst_i.r.funct)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADDU;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUBU;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_XOR:  ctrl_o.alu_op = ALU_XOR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        // rt shifted by shamt, rs is not read
                        ctrl_o.alu_op      = ALU_SLL;
                        ctrl_o.uses_rs     = 1'b0;
                        ctrl_o.src_a_shamt = 1'b1;
                        ctrl_o.imm_value   = {{(DATA_W-5){1'b0}}, inst_i.r.shamt};
                    end
                    default: begin
                        ctrl_o.uses_rs = 1'b0;
                        ctrl_o.uses_rt = 1'b0;
                        ctrl_o.reg_wen = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.waddr     = inst_i.i.rt;
                ctrl_o.uses_rs   = 1'b1;
                ctrl_o.reg_wen   = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.alu_op    = ALU_ADDIU;
                ctrl_o.imm_value = {{(DATA_W-16){inst_i.i.imm[15]}}, inst_i.i.imm};
            end
            OP_ORI: begin
                ctrl_o.waddr     = inst_i.i.rt;
                ctrl_o.uses_rs   = 1'b1;
                ctrl_o.reg_wen   = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.alu_op    = ALU_ORI;
                ctrl_o.imm_value = {{(DATA_W-16){1'b0}}, inst_i.i.imm};
            end
            OP_LUI: begin
                ctrl_o.waddr     = inst_i.i.rt;
                ctrl_o.reg_wen   = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.alu_op    = ALU_LUI;
                ctrl_o.imm_value = {inst_i.i.imm, {(DATA_W-16){1'b0}}};
            end
            default: begin
                ctrl_o.reg_wen = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/regfile.sv
module regfile (
    input  logic                                       clk,
    input  logic                                       arst_n_i,
    input  logic [3:0][dual_issue_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [3:0][dual_issue_pkg::DATA_W-1:0]     rdata_o,
    input  dual_issue_pkg::retire_t                    wr_master_i,
    input  dual_issue_pkg::retire_t                    wr_slave_i
);
    import dual_issue_pkg::*;

    logic [NUM_REGS-1:0][DATA_W-1:0] regs_q;
    logic                            wen_master;
    logic                            wen_slave;

    assign wen_master = wr_master_i.valid && wr_master_i.reg_wen && (wr_master_i.waddr != '0);
    assign wen_slave  = wr_slave_i.valid && wr_slave_i.reg_wen && (wr_slave_i.waddr != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '0;
        end else begin
            if (wen_master) begin
                regs_q[wr_master_i.waddr] <= wr_master_i.wdata;
            end
            // slave is the younger one, its write lands last
            if (wen_slave) begin
                regs_q[wr_slave_i.waddr] <= wr_slave_i.wdata;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata_o[i] = (raddr_i[i] == '0) ? '0 : regs_q[raddr_i[i]];
        end
    end

endmodule

//--- hdl/issue_ctrl.sv
module issue_ctrl #(
    parameter int FIFO_DEPTH = 8
) (
    input  dual_issue_pkg::lane_ctrl_t      master_i,
    input  dual_issue_pkg::lane_ctrl_t      slave_i,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] count_i,
    output logic                            slave_issue_o
);

    logic master_writes;
    logic raw_rs;
    logic raw_rt;

    // r0 never creates a dependency
    assign master_writes = master_i.reg_wen && (master_i.waddr != '0);
    assign raw_rs        = slave_i.uses_rs && (slave_i.rs == master_i.waddr);
    assign raw_rt        = slave_i.uses_rt && (slave_i.rt == master_i.waddr);

    assign slave_issue_o = (count_i >= 2) && !(master_writes && (raw_rs || raw_rt));

endmodule

//--- hdl/forward_unit.sv
module forward_unit (
    input  logic [3:0][dual_issue_pkg::REG_ADDR_W-1:0] raddr_i,
    input  logic [3:0][dual_issue_pkg::DATA_W-1:0]     rf_data_i,
    input  dual_issue_pkg::retire_t                    ex_master_i,
    input  dual_issue_pkg::retire_t                    ex_slave_i,
    input  dual_issue_pkg::retire_t                    wb_master_i,
    input  dual_issue_pkg::retire_t                    wb_slave_i,
    output logic [3:0][dual_issue_pkg::DATA_W-1:0]     operand_o
);
    import dual_issue_pkg::*;

    function automatic logic hit(input retire_t src, input logic [REG_ADDR_W-1:0] addr);
        return src.valid && src.reg_wen && (src.waddr == addr);
    endfunction

    // youngest producer first
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (raddr_i[i] == '0) begin
                operand_o[i] = '0;
            end else if (hit(ex_slave_i, raddr_i[i])) begin
                operand_o[i] = ex_slave_i.wdata;
            end else if (hit(ex_master_i, raddr_i[i])) begin
                operand_o[i] = ex_master_i.wdata;
            end else if (hit(wb_slave_i, raddr_i[i])) begin
                operand_o[i] = wb_slave_i.wdata;
            end else if (hit(wb_master_i, raddr_i[i])) begin
                operand_o[i] = wb_master_i.wdata;
            end else begin
                operand_o[i] = rf_data_i[i];
            end
        end
    end

endmodule

//--- hdl/alu.sv
module alu (
    input  dual_issue_pkg::exec_t   lane_i,
    output dual_issue_pkg::retire_t result_o
);
    import dual_issue_pkg::*;

    localparam int SH_W = $clog2(DATA_W);

    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;
    logic [DATA_W-1:0] res;
    logic              less;

    assign src_a = lane_i.ctrl.src_a_shamt ? lane_i.ctrl.imm_value : lane_i.rs_value;
    assign src_b = lane_i.ctrl.src_b_imm ? lane_i.ctrl.imm_value : lane_i.rt_value;
    assign less  = $signed(src_a) < $signed(src_b);

    always_comb begin
        case (lane_i.ctrl.alu_op)
            ALU_ADDU, ALU_ADDIU: res = src_a + src_b;
            ALU_SUBU:            res = src_a - src_b;
            ALU_AND:             res = src_a & src_b;
            ALU_OR, ALU_ORI:     res = src_a | src_b;
            ALU_XOR:             res = src_a ^ src_b;
            ALU_SLT:             res = {{(DATA_W-1){1'b0}}, less};
            ALU_SLL:             res = src_b << src_a[SH_W-1:0];
            // immediate already sits in the upper half
            ALU_LUI:             res = src_b;
            default:             res = '0;
        endcase
    end

    always_comb begin
        result_o.valid   = lane_i.valid;
        result_o.reg_wen = lane_i.ctrl.reg_wen;
        result_o.waddr   = lane_i.ctrl.waddr;
        result_o.wdata   = res;
    end

endmodule

//--- hdl/dual_issue_core.sv
module dual_issue_core #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    inst_valid_i,
    input  dual_issue_pkg::inst_u   inst_i,
    output logic                    fifo_full_o,
    output dual_issue_pkg::retire_t retire_master_o,
    output dual_issue_pkg::retire_t retire_slave_o
);
    import dual_issue_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0]                 fifo_count;
    inst_u                            head_inst;
    inst_u                            next_inst;
    logic                             fifo_push;
    logic                             master_issue;
    logic                             slave_issue;
    logic                             pop_one;
    logic                             pop_two;
    lane_ctrl_t                       master_ctrl;
    lane_ctrl_t                       slave_ctrl;
    logic [3:0][REG_ADDR_W-1:0]       raddr;
    logic [3:0][DATA_W-1:0]           rf_data;
    logic [3:0][DATA_W-1:0]           operand;
    exec_t                            ex_master_q;
    exec_t                            ex_slave_q;
    retire_t                          ex_master_res;
    retire_t                          ex_slave_res;
    retire_t                          wb_master_q;
    retire_t                          wb_slave_q;

    assign fifo_push = inst_valid_i && !fifo_full_o;

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_inst_fifo (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .push_i      (fifo_push),
        .push_data_i (inst_i),
        .pop_one_i   (pop_one),
        .pop_two_i   (pop_two),
        .head_o      (head_inst),
        .next_o      (next_inst),
        .count_o     (fifo_count),
        .full_o      (fifo_full_o)
    );

    inst_decoder u_decoder_master (
        .inst_i (head_inst),
        .ctrl_o (master_ctrl)
    );

    inst_decoder u_decoder_slave (
        .inst_i (next_inst),
        .ctrl_o (slave_ctrl)
    );

    issue_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_issue_ctrl (
        .master_i      (master_ctrl),
        .slave_i       (slave_ctrl),
        .count_i       (fifo_count),
        .slave_issue_o (slave_issue)
    );

    // master goes whenever the queue has a word
    assign master_issue = (fifo_count != '0);
    assign pop_two      = slave_issue;
    assign pop_one      = master_issue && !slave_issue;

    assign raddr[0] = master_ctrl.rs;
    assign raddr[1] = master_ctrl.rt;
    assign raddr[2] = slave_ctrl.rs;
    assign raddr[3] = slave_ctrl.rt;

    regfile u_regfile (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .raddr_i     (raddr),
        .rdata_o     (rf_data),
        .wr_master_i (wb_master_q),
        .wr_slave_i  (wb_slave_q)
    );

    forward_unit u_forward_unit (
        .raddr_i     (raddr),
        .rf_data_i   (rf_data),
        .ex_master_i (ex_master_res),
        .ex_slave_i  (ex_slave_res),
        .wb_master_i (wb_master_q),
        .wb_slave_i  (wb_slave_q),
        .operand_o   (operand)
    );

    // decode to execute
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_master_q <= '0;
            ex_slave_q  <= '0;
        end else begin
            ex_master_q.valid    <= master_issue;
            ex_master_q.ctrl     <= master_ctrl;
            ex_master_q.rs_value <= operand[0];
            ex_master_q.rt_value <= operand[1];
            ex_slave_q.valid     <= slave_issue;
            ex_slave_q.ctrl      <= slave_ctrl;
            ex_slave_q.rs_value  <= operand[2];
            ex_slave_q.rt_value  <= operand[3];
        end
    end

    alu u_alu_master (
        .lane_i   (ex_master_q),
        .result_o (ex_master_res)
    );

    alu u_alu_slave (
        .lane_i   (ex_slave_q),
        .result_o (ex_slave_res)
    );

    // execute to writeback
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_master_q <= '0;
            wb_slave_q  <= '0;
        end else begin
            wb_master_q <= ex_master_res;
            wb_slave_q  <= ex_slave_res;
        end
    end

    assign retire_master_o = wb_master_q;
    assign retire_slave_o  = wb_slave_q;

endmodule

//--- sim/clk_gen.sv
module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

//--- sim/dual_issue_checker.sv
module dual_issue_checker #(
    parameter int FIFO_DEPTH = 8
) (
    input logic                                clk_i,
    input logic                                arst_n_i,
    input logic                                push_i,
    input logic                                full_i,
    input logic                                pop_two_i,
    input logic [$clog2(FIFO_DEPTH+1)-1:0]     count_i,
    input dual_issue_pkg::retire_t             retire_master_i,
    input dual_issue_pkg::retire_t             retire_slave_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // bumped on every failed assertion
    int unsigned err_count = 0;

    // offered word is not taken while full, occupancy only drops by the pop
    push_not_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_i && full_i |=> count_i == FIFO_DEPTH - ($past(pop_two_i) ? 2 : 1))
        else begin
            $error("fifo took a word while full");
            err_count++;
        end

    retire_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(retire_master_i.valid) && !$isunknown(retire_slave_i.valid))
        else begin
            $error("retire valid is unknown");
            err_count++;
        end

    slave_needs_master: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        retire_slave_i.valid |-> retire_master_i.valid)
        else begin
            $error("slave retired without a master");
            err_count++;
        end

endmodule

//--- sim/tb_dual_issue.sv
module tb_dual_issue;
    timeunit 1ns;
    timeprecision 1ps;
    import dual_issue_pkg::*;

    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        inst_u      inst;
        logic [3:0] gap;
    } stim_t;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    inst_u       inst;
    logic        fifo_full;
    retire_t     retire_master;
    retire_t     retire_slave;
    stim_t       stim_q [$];
    retire_t     exp_q [$];
    logic [31:0] ref_regs [NUM_REGS];
    logic [31:0] lcg_state = 32'd59865;
    int          gap_sum = 0;
    int          timeout_limit = 0;
    int          cycle_count = 0;

    clk_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    dual_issue_core #(
        .FIFO_DEPTH (4)
    ) dual_issue_core_i (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .inst_valid_i    (inst_valid),
        .inst_i          (inst),
        .fifo_full_o     (fifo_full),
        .retire_master_o (retire_master),
        .retire_slave_o  (retire_slave)
    );

    bind dual_issue_core dual_issue_checker #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_checker (
        .clk_i           (clk),
        .arst_n_i        (arst_n_i),
        .push_i          (inst_valid_i),
        .full_i          (fifo_full_o),
        .pop_two_i       (pop_two),
        .count_i         (fifo_count),
        .retire_master_i (retire_master_o),
        .retire_slave_i  (retire_slave_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'h0, lcg_state[31:16]};
    endfunction

    function automatic inst_u enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                    input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] sh);
        inst_u w;
        w.r = '{op: OP_SPECIAL, rs: rs, rt: rt, rd: rd, shamt: sh, funct: fn};
        return w;
    endfunction

    function automatic inst_u enc_i(input logic [5:0] op, input logic [4:0] rt,
                                    input logic [4:0] rs, input logic [15:0] imm);
        inst_u w;
        w.i = '{op: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    // program-order model of the instruction set
    function automatic retire_t ref_step(input inst_u w);
        retire_t     r;
        logic [31:0] a;
        logic [31:0] b;
        a = ref_regs[w.r.rs];
        b = ref_regs[w.r.rt];
        r = '0;
        r.valid = 1'b1;
        r.reg_wen = 1'b1;
        r.waddr = (w.r.op == OP_SPECIAL) ? w.r.rd : w.i.rt;
        case (w.r.op)
            OP_ADDIU: r.wdata = a + {{16{w.i.imm[15]}}, w.i.imm};
            OP_ORI:   r.wdata = a | {16'h0, w.i.imm};
            OP_LUI:   r.wdata = {w.i.imm, 16'h0};
            default: begin
                case (w.r.funct)
                    FN_ADDU: r.wdata = a + b;
                    FN_SUBU: r.wdata = a - b;
                    FN_AND:  r.wdata = a & b;
                    FN_OR:   r.wdata = a | b;
                    FN_XOR:  r.wdata = a ^ b;
                    FN_SLT:  r.wdata = {31'h0, $signed(a) < $signed(b)};
                    default: r.wdata = b << w.r.shamt;
                endcase
            end
        endcase
        if (r.waddr != 5'd0) begin
            ref_regs[r.waddr] = r.wdata;
        end
        return r;
    endfunction

    task automatic add(input inst_u w, input int gap);
        stim_q.push_back('{inst: w, gap: 4'(gap)});
        gap_sum += gap;
    endtask

    task automatic build_table();
        logic [5:0]  fn_tab [7];
        logic [5:0]  op_tab [3];
        logic [31:0] pick;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sh;
        logic [15:0] imm;
        int          gap_len;
        fn_tab = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL};
        op_tab = '{OP_ADDIU, OP_ORI, OP_LUI};
        // independent ops, spaced out
        add(enc_i(OP_LUI, 5'd1, 5'd0, 16'h1234), 3);
        add(enc_i(OP_ORI, 5'd1, 5'd1, 16'h5678), 3);
        add(enc_i(OP_LUI, 5'd2, 5'd0, 16'h8000), 3);
        add(enc_i(OP_ORI, 5'd2, 5'd2, 16'h0003), 3);
        add(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'hfffb), 3);
        for (int k = 0; k < 7; k++) begin
            add(enc_r(fn_tab[k], 5'(4 + k), 5'd1, 5'd2, 5'd4), 3);
        end
        add(enc_r(FN_SLT, 5'd11, 5'd2, 5'd1, 5'd0), 3);
        add(enc_i(OP_ADDIU, 5'd12, 5'd3, 16'd100), 3);
        add(enc_i(OP_ORI, 5'd13, 5'd2, 16'hf0f0), 3);
        // back-to-back chain through forwarding
        add(enc_i(OP_ADDIU, 5'd15, 5'd0, 16'd1), 0);
        for (int k = 0; k < 5; k++) begin
            add(enc_r(FN_ADDU, 5'd15, 5'd15, 5'd15, 5'd0), 0);
        end
        add(enc_r(FN_SUBU, 5'd16, 5'd15, 5'd1, 5'd0), 0);
        add(enc_r(FN_XOR, 5'd16, 5'd16, 5'd15, 5'd0), 0);
        add(enc_r(FN_SLL, 5'd16, 5'd0, 5'd16, 5'd3), 0);
        // r0 stays zero
        add(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'd7), 0);
        add(enc_r(FN_ADDU, 5'd17, 5'd0, 5'd1, 5'd0), 0);
        add(enc_i(OP_LUI, 5'd0, 5'd0, 16'hffff), 0);
        add(enc_r(FN_OR, 5'd18, 5'd0, 5'd0, 5'd0), 0);
        for (int k = 0; k < 16; k++) begin
            add(enc_i(OP_ADDIU, 5'(20 + k % 8), 5'(19 + k % 8), 16'(k * 3)), 0);
        end
        for (int k = 0; k < 200; k++) begin
            pick = lcg_next() % 10;
            rd = 5'(lcg_next() % 8);
            rs = 5'(lcg_next() % 8);
            rt = 5'(lcg_next() % 8);
            sh = 5'(lcg_next());
            if (pick < 7) begin
                add(enc_r(fn_tab[pick], rd, rs, rt, (pick == 6) ? sh : 5'd0), 0);
            end else begin
                imm = 16'(lcg_next());
                gap_len = (lcg_next() % 4 == 0) ? int'(lcg_next() % 3) : 0;
                add(enc_i(op_tab[pick - 7], rd, rs, imm), gap_len);
            end
        end
        foreach (ref_regs[k]) begin
            ref_regs[k] = '0;
        end
        foreach (stim_q[k]) begin
            exp_q.push_back(ref_step(stim_q[k].inst));
        end
    endtask

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_retire(input retire_t act, input retire_t exp, input int idx);
        if (act !== exp) begin
            $display("MISMATCH at %0t: instruction %0d retired v%b w%b r%0d %h, expected r%0d %h",
                     $time, idx, act.valid, act.reg_wen, act.waddr, act.wdata,
                     exp.waddr, exp.wdata);
            stop_run();
        end
    endtask

    task automatic check_count(input int act, input int exp);
        if (act != exp) begin
            $display("MISMATCH at %0t: %0d instructions retired, expected %0d",
                     $time, act, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic drive_program();
        logic accepted;
        @(posedge clk);
        foreach (stim_q[k]) begin
            inst_valid <= 1'b1;
            inst       <= stim_q[k].inst;
            accepted = 1'b0;
            // word stays on the bus until the fifo has room
            while (!accepted) begin
                @(negedge clk);
                accepted = !fifo_full;
                @(posedge clk);
            end
            if (stim_q[k].gap != 0) begin
                inst_valid <= 1'b0;
                repeat (stim_q[k].gap) @(posedge clk);
            end
        end
        inst_valid <= 1'b0;
    endtask

    // extra retires are only counted, check_count catches them
    task automatic take_retire(input retire_t r, inout int seen);
        if (seen < exp_q.size()) begin
            check_retire(r, exp_q[seen], seen);
        end
        seen++;
    endtask

    task automatic watch_retire();
        int seen;
        seen = 0;
        while (seen < exp_q.size()) begin
            @(negedge clk);
            if (dual_issue_core_i.u_checker.err_count != 0) begin
                report_failure("a bound assertion failed");
            end
            if (retire_master.valid === 1'b1) begin
                take_retire(retire_master, seen);
            end
            if (retire_slave.valid === 1'b1) begin
                take_retire(retire_slave, seen);
            end
        end
        // drain window for late duplicates
        repeat (6) begin
            @(negedge clk);
            if (retire_master.valid === 1'b1) begin
                seen++;
            end
            if (retire_slave.valid === 1'b1) begin
                seen++;
            end
        end
        check_count(seen, stim_q.size());
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            report_failure("timeout, the program did not retire in time");
        end
    end

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        build_table();
        timeout_limit = 4 * (stim_q.size() + RESET_CYCLES + gap_sum);
        @(posedge arst_n);
        repeat (2) @(negedge clk);
        check_flag(fifo_full, 1'b0, "fifo_full_o after reset");
        check_flag(retire_master.valid, 1'b0, "master retire valid after reset");
        check_flag(retire_slave.valid, 1'b0, "slave retire valid after reset");
        fork
            drive_program();
            watch_retire();
        join
        if (dual_issue_core_i.u_checker.err_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("a bound assertion failed");
        end
    end

endmodule

//--- sources.f
hdl/dual_issue_pkg.sv
hdl/inst_fifo.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/issue_ctrl.sv
hdl/forward_unit.sv
hdl/alu.sv
hdl/dual_issue_core.sv
sim/clk_gen.sv
sim/dual_issue_checker.sv
sim/tb_dual_issue.sv
